// ==== axi_pkg.sv ====
// shared widths, typedefs, request/response and AXI channel structs, FSM states, AXI constants
package axi_pkg;

  // ------------------------------------------------
  // widths
  // ------------------------------------------------
  typedef logic [31:0] addr_t;   // byte address
  typedef logic [63:0] data_t;   // one RAM word
  typedef logic [7:0]  strb_t;   // byte lanes
  typedef logic [1:0]  size_t;   // log2 bytes per beat
  typedef logic [1:0]  resp_t;
  typedef logic [7:0]  len_t;    // beats minus one
  typedef logic [1:0]  burst_t;
  typedef logic [3:0]  cache_t;
  typedef logic [2:0]  prot_t;

  // ------------------------------------------------
  // AXI constants
  // ------------------------------------------------
  localparam resp_t  RESP_OKAY        = 2'b00;
  localparam resp_t  RESP_SLVERR      = 2'b10;
  localparam len_t   LEN_SINGLE       = 8'd0;    // one beat only
  localparam burst_t BURST_INCR       = 2'b01;
  localparam prot_t  PROT_DATA_SECURE = 3'b000;  // unprivileged, secure, data
  localparam cache_t CACHE_DEV_NONBUF = 4'b0000;

  // on-chip RAM map
  localparam addr_t       MEM_BASE   = 32'h8000_0000;
  localparam int unsigned MEM_WORDS  = 512;
  localparam int unsigned MEM_IDX_W  = 9;
  localparam int unsigned WORD_OFF_W = 3;        // byte offset bits inside a word

  // ------------------------------------------------
  // payload structs
  // ------------------------------------------------
  typedef struct packed {
    logic  wr;     // 1 = write
    size_t size;
    addr_t addr;
    strb_t strb;
    data_t data;
  } rw_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;    // non-OKAY response seen
  } rw_rsp_t;

  typedef struct packed {
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    logic   lock;
    cache_t cache;
    prot_t  prot;
  } axi_ax_t;      // AW and AR payload

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
    logic  last;
  } axi_r_t;

  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;
  typedef enum logic [1:0] {WR_IDLE, WR_XFER, WR_RESP} wr_state_e;

endpackage

// ==== rw_arbiter.sv ====
// request arbiter between fetch and data ports, data port first, grant held until data_ok
`timescale 1ns/1ps

module rw_arbiter import axi_pkg::*; (
  input  logic    i_aclk,
  input  logic    i_rst,
  // fetch port, read only
  input  logic    i_if_req,
  input  addr_t   i_if_addr,
  input  size_t   i_if_size,
  output logic    o_if_addr_ok,
  output logic    o_if_data_ok,
  // data port
  input  logic    i_mem_req,
  input  rw_req_t i_mem_rw,
  output logic    o_mem_addr_ok,
  output logic    o_mem_data_ok,
  // shared response
  output rw_rsp_t o_rsp,
  // toward the bridge
  output logic    o_bus_req,
  output rw_req_t o_bus_rw,
  input  logic    i_bus_addr_ok,
  input  logic    i_bus_data_ok,
  input  rw_rsp_t i_bus_rsp
);

  logic    busy_q;     // transaction open at the bridge
  logic    gnt_mem_q;  // owner of the open transaction
  logic    free;
  rw_req_t if_rw;

  // fetch port only carries address and size
  always_comb begin
    if_rw      = '0;
    if_rw.size = i_if_size;
    if_rw.addr = i_if_addr;
  end

  // ------------------------------------------------
  // selection and forwarding
  // ------------------------------------------------
  assign free      = ~busy_q | i_bus_data_ok;     // slot frees in the data_ok cycle
  assign o_bus_req = free & (i_if_req | i_mem_req);
  assign o_bus_rw  = i_mem_req ? i_mem_rw : if_rw; // data port wins a tie

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      busy_q    <= 1'b0;
      gnt_mem_q <= 1'b0;
    end else if (o_bus_req) begin
      busy_q    <= 1'b1;
      gnt_mem_q <= i_mem_req;  // remembered until data_ok
    end else if (i_bus_data_ok) begin
      busy_q    <= 1'b0;
    end
  end

  // ------------------------------------------------
  // handshake routing
  // ------------------------------------------------
  assign o_if_addr_ok  = i_bus_addr_ok & ~gnt_mem_q;
  assign o_mem_addr_ok = i_bus_addr_ok &  gnt_mem_q;
  assign o_if_data_ok  = i_bus_data_ok & ~gnt_mem_q;
  assign o_mem_data_ok = i_bus_data_ok &  gnt_mem_q;
  assign o_rsp         = i_bus_rsp;

endmodule

// ==== axi4_master_bridge.sv ====
// AXI4 master bridge, one request turned into a single-beat read or write transaction
`timescale 1ns/1ps

module axi4_master_bridge import axi_pkg::*; (
  input  logic    i_aclk,
  input  logic    i_rst,
  // request side
  input  logic    i_req,
  input  rw_req_t i_rw,
  output logic    o_addr_ok,
  output logic    o_data_ok,
  output rw_rsp_t o_rsp,
  // write address / data / response
  output axi_ax_t o_aw,
  output logic    o_awvalid,
  input  logic    i_awready,
  output axi_w_t  o_w,
  output logic    o_wvalid,
  input  logic    i_wready,
  input  logic    i_bvalid,
  input  resp_t   i_bresp,
  output logic    o_bready,
  // read address / data
  output axi_ax_t o_ar,
  output logic    o_arvalid,
  input  logic    i_arready,
  input  logic    i_rvalid,
  input  axi_r_t  i_r,
  output logic    o_rready
);

  rd_state_e rd_state_q;
  wr_state_e wr_state_q;
  rw_req_t   req_q;      // latched request
  axi_ax_t   ax;
  rw_rsp_t   rsp_q;
  logic      data_ok_q;
  logic      accept;
  logic      ar_fire;
  logic      r_fire;
  logic      aw_fire;
  logic      w_fire;
  logic      b_fire;

  assign ar_fire = o_arvalid & i_arready;
  assign r_fire  = o_rready  & i_rvalid;
  assign aw_fire = o_awvalid & i_awready;
  assign w_fire  = o_wvalid  & i_wready;
  assign b_fire  = o_bready  & i_bvalid;

  // one transaction in flight, both machines must be idle
  assign accept = i_req & (rd_state_q == RD_IDLE) & (wr_state_q == WR_IDLE);

  always_ff @(posedge i_aclk) begin
    if (accept) begin
      req_q <= i_rw;
    end
  end

  // ------------------------------------------------
  // read FSM
  // ------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      rd_state_q <= RD_IDLE;
    end else begin
      case (rd_state_q)
        RD_IDLE: if (accept && !i_rw.wr) rd_state_q <= RD_ADDR;
        RD_ADDR: if (ar_fire) rd_state_q <= RD_DATA;
        RD_DATA: if (r_fire) rd_state_q <= RD_IDLE;
        default: rd_state_q <= RD_IDLE;
      endcase
    end
  end

  // ------------------------------------------------
  // write FSM
  // ------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      wr_state_q <= WR_IDLE;
    end else begin
      case (wr_state_q)
        WR_IDLE: if (accept && i_rw.wr) wr_state_q <= WR_XFER;
        WR_XFER: if (aw_fire && w_fire) wr_state_q <= WR_RESP;
        WR_RESP: if (b_fire) wr_state_q <= WR_IDLE;
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  // fixed single-beat attributes
  always_comb begin
    ax       = '0;
    ax.addr  = req_q.addr;
    ax.len   = LEN_SINGLE;
    ax.size  = req_q.size;
    ax.burst = BURST_INCR;
    ax.lock  = 1'b0;
    ax.cache = CACHE_DEV_NONBUF;
    ax.prot  = PROT_DATA_SECURE;
  end

  assign o_ar      = ax;
  assign o_aw      = ax;
  assign o_w.data  = req_q.data;
  assign o_w.strb  = req_q.strb;
  assign o_w.last  = 1'b1;

  assign o_arvalid = (rd_state_q == RD_ADDR);
  assign o_rready  = (rd_state_q == RD_DATA);  // never stalls the slave
  assign o_awvalid = (wr_state_q == WR_XFER);  // AW and W go together
  assign o_wvalid  = (wr_state_q == WR_XFER);
  assign o_bready  = (wr_state_q == WR_RESP);

  // ------------------------------------------------
  // response back to the requester
  // ------------------------------------------------
  assign o_addr_ok = ar_fire | (aw_fire & w_fire);

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      data_ok_q <= 1'b0;
    end else begin
      data_ok_q <= r_fire | b_fire;  // one-cycle pulse after the transfer
    end
  end

  always_ff @(posedge i_aclk) begin
    if (r_fire) begin
      rsp_q.rdata <= i_r.data;
      rsp_q.err   <= (i_r.resp != RESP_OKAY);
    end else if (b_fire) begin
      rsp_q.rdata <= '0;
      rsp_q.err   <= (i_bresp != RESP_OKAY);
    end
  end

  assign o_data_ok = data_ok_q;
  assign o_rsp     = rsp_q;

endmodule

// ==== axi4_sram_slave.sv ====
// AXI4 slave with a 512x64 RAM, byte strobes, address range check and responses
`timescale 1ns/1ps

module axi4_sram_slave import axi_pkg::*; (
  input  logic    i_aclk,
  input  logic    i_rst,
  // write side
  input  axi_ax_t i_aw,
  input  logic    i_awvalid,
  output logic    o_awready,
  input  axi_w_t  i_w,
  input  logic    i_wvalid,
  output logic    o_wready,
  output logic    o_bvalid,
  output resp_t   o_bresp,
  input  logic    i_bready,
  // read side
  input  axi_ax_t i_ar,
  input  logic    i_arvalid,
  output logic    o_arready,
  output logic    o_rvalid,
  output axi_r_t  o_r,
  input  logic    i_rready
);

  data_t                mem [MEM_WORDS];
  logic                 wr_go;
  logic                 ar_go;
  logic                 b_fire;
  logic                 r_fire;
  logic                 aw_hit;
  logic                 ar_hit;
  logic [MEM_IDX_W-1:0] aw_idx;
  logic [MEM_IDX_W-1:0] ar_idx;
  logic                 bvalid_q;
  resp_t                bresp_q;
  logic                 rvalid_q;
  axi_r_t               r_q;

  // ------------------------------------------------
  // address decode
  // ------------------------------------------------
  function automatic logic addr_hit(addr_t a);
    addr_t off;
    off = a - MEM_BASE;  // below base wraps to a large offset
    return off[$bits(addr_t)-1:WORD_OFF_W] < MEM_WORDS;
  endfunction

  function automatic logic [MEM_IDX_W-1:0] word_idx(addr_t a);
    addr_t off;
    off = a - MEM_BASE;
    return off[WORD_OFF_W +: MEM_IDX_W];
  endfunction

  assign aw_hit = addr_hit(i_aw.addr);
  assign ar_hit = addr_hit(i_ar.addr);
  assign aw_idx = word_idx(i_aw.addr);
  assign ar_idx = word_idx(i_ar.addr);

  // ------------------------------------------------
  // write path
  // ------------------------------------------------
  assign wr_go     = i_awvalid & i_wvalid & ~bvalid_q;  // AW and W taken together
  assign o_awready = wr_go;
  assign o_wready  = wr_go;
  assign b_fire    = bvalid_q & i_bready;

  always_ff @(posedge i_aclk) begin
    if (wr_go && aw_hit) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (i_w.strb[b]) begin
          mem[aw_idx][8*b +: 8] <= i_w.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      bvalid_q <= 1'b0;
    end else if (wr_go) begin
      bvalid_q <= 1'b1;
    end else if (b_fire) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (wr_go) begin
      bresp_q <= aw_hit ? RESP_OKAY : RESP_SLVERR;  // miss leaves RAM untouched
    end
  end

  // ------------------------------------------------
  // read path
  // ------------------------------------------------
  assign o_arready = ~rvalid_q;  // no R pending
  assign ar_go     = i_arvalid & ~rvalid_q;
  assign r_fire    = rvalid_q & i_rready;

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      rvalid_q <= 1'b0;
    end else if (ar_go) begin
      rvalid_q <= 1'b1;
    end else if (r_fire) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_go) begin
      r_q.data <= ar_hit ? mem[ar_idx] : '0;
      r_q.resp <= ar_hit ? RESP_OKAY : RESP_SLVERR;
      r_q.last <= 1'b1;
    end
  end

  assign o_bvalid = bvalid_q;
  assign o_bresp  = bresp_q;
  assign o_rvalid = rvalid_q;
  assign o_r      = r_q;

endmodule

// ==== axi_subsys_top.sv ====
// top level connecting the request arbiter, the AXI4 master bridge and the RAM slave
`timescale 1ns/1ps

module axi_subsys_top import axi_pkg::*; (
  input  logic    i_aclk,
  input  logic    i_rst,
  input  logic    i_if_req,
  input  addr_t   i_if_addr,
  input  size_t   i_if_size,
  output logic    o_if_addr_ok,
  output logic    o_if_data_ok,
  input  logic    i_mem_req,
  input  rw_req_t i_mem_rw,
  output logic    o_mem_addr_ok,
  output logic    o_mem_data_ok,
  output rw_rsp_t o_rsp
);

  // arbiter to bridge
  logic    bus_req;
  rw_req_t bus_rw;
  logic    bus_addr_ok;
  logic    bus_data_ok;
  rw_rsp_t bus_rsp;

  // ------------------------------------------------
  // AXI4 channels
  // ------------------------------------------------
  axi_ax_t aw;
  logic    awvalid;
  logic    awready;
  axi_w_t  w;
  logic    wvalid;
  logic    wready;
  logic    bvalid;
  resp_t   bresp;
  logic    bready;
  axi_ax_t ar;
  logic    arvalid;
  logic    arready;
  axi_r_t  r;
  logic    rvalid;
  logic    rready;

  rw_arbiter u_arb (
    .i_aclk        (i_aclk),
    .i_rst         (i_rst),
    .i_if_req      (i_if_req),
    .i_if_addr     (i_if_addr),
    .i_if_size     (i_if_size),
    .o_if_addr_ok  (o_if_addr_ok),
    .o_if_data_ok  (o_if_data_ok),
    .i_mem_req     (i_mem_req),
    .i_mem_rw      (i_mem_rw),
    .o_mem_addr_ok (o_mem_addr_ok),
    .o_mem_data_ok (o_mem_data_ok),
    .o_rsp         (o_rsp),
    .o_bus_req     (bus_req),
    .o_bus_rw      (bus_rw),
    .i_bus_addr_ok (bus_addr_ok),
    .i_bus_data_ok (bus_data_ok),
    .i_bus_rsp     (bus_rsp)
  );

  axi4_master_bridge u_bridge (
    .i_aclk    (i_aclk),
    .i_rst     (i_rst),
    .i_req     (bus_req),
    .i_rw      (bus_rw),
    .o_addr_ok (bus_addr_ok),
    .o_data_ok (bus_data_ok),
    .o_rsp     (bus_rsp),
    .o_aw      (aw),
    .o_awvalid (awvalid),
    .i_awready (awready),
    .o_w       (w),
    .o_wvalid  (wvalid),
    .i_wready  (wready),
    .i_bvalid  (bvalid),
    .i_bresp   (bresp),
    .o_bready  (bready),
    .o_ar      (ar),
    .o_arvalid (arvalid),
    .i_arready (arready),
    .i_rvalid  (rvalid),
    .i_r       (r),
    .o_rready  (rready)
  );

  axi4_sram_slave u_sram (
    .i_aclk    (i_aclk),
    .i_rst     (i_rst),
    .i_aw      (aw),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_w       (w),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .o_bvalid  (bvalid),
    .o_bresp   (bresp),
    .i_bready  (bready),
    .i_ar      (ar),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .o_rvalid  (rvalid),
    .o_r       (r),
    .i_rready  (rready)
  );

endmodule

// ==== axi_subsys_properties.sv ====
// concurrent assertions on the AXI handshakes of the master bridge, plus the bind
`timescale 1ns/1ps

module axi_subsys_properties import axi_pkg::*; (
  input logic    i_aclk,
  input logic    i_rst,
  input axi_ax_t i_aw,
  input logic    i_awvalid,
  input logic    i_awready,
  input axi_w_t  i_w,
  input logic    i_wvalid,
  input logic    i_wready,
  input axi_ax_t i_ar,
  input logic    i_arvalid,
  input logic    i_arready
);

  // --------------------------------------------------
  // valid and payload held until ready
  // --------------------------------------------------
  aw_hold: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_awvalid && !i_awready |=> i_awvalid && $stable(i_aw))
    else $error("AW valid dropped or payload changed before awready");

  w_hold: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_wvalid && !i_wready |=> i_wvalid && $stable(i_w))
    else $error("W valid dropped or payload changed before wready");

  ar_hold: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_arvalid && !i_arready |=> i_arvalid && $stable(i_ar))
    else $error("AR valid dropped or payload changed before arready");

  // write address and data travel together
  aw_w_pair: assert property (@(posedge i_aclk) disable iff (i_rst)
    (i_awvalid == i_wvalid) && ((i_awvalid && i_awready) == (i_wvalid && i_wready)))
    else $error("awvalid and wvalid differ or AW and W transferred in different cycles");

  one_dir: assert property (@(posedge i_aclk) disable iff (i_rst)
    !(i_arvalid && i_awvalid))
    else $error("read and write address valid at the same time");

  // valids low once reset has been applied
  rst_quiet: assert property (@(posedge i_aclk)
    i_rst |=> !i_awvalid && !i_wvalid && !i_arvalid)
    else $error("valid high right after reset");

endmodule

bind axi4_master_bridge axi_subsys_properties u_props (
  .i_aclk    (i_aclk),
  .i_rst     (i_rst),
  .i_aw      (o_aw),
  .i_awvalid (o_awvalid),
  .i_awready (i_awready),
  .i_w       (o_w),
  .i_wvalid  (o_wvalid),
  .i_wready  (i_wready),
  .i_ar      (o_ar),
  .i_arvalid (o_arvalid),
  .i_arready (i_arready)
);

// ==== tb_axi_subsys.sv ====
// testbench for the AXI subsystem: case file loader, requester drivers, response checks
`timescale 1ns/1ps

module tb_axi_subsys import axi_pkg::*; ();

  localparam int WAIT_LIMIT = 50;  // cycles allowed per handshake wait

  typedef struct {
    int      port;   // 0 fetch, 1 data, 2 data issued with the next fetch case
    rw_req_t rw;
    rw_rsp_t exp;
  } case_t;

  logic    i_aclk;
  logic    i_rst;
  logic    i_if_req;
  addr_t   i_if_addr;
  size_t   i_if_size;
  logic    o_if_addr_ok;
  logic    o_if_data_ok;
  logic    i_mem_req;
  rw_req_t i_mem_rw;
  logic    o_mem_addr_ok;
  logic    o_mem_data_ok;
  rw_rsp_t o_rsp;

  case_t   cases[$];
  int      cycle_cnt = 0;
  int      mem_ok_cyc;
  int      if_ok_cyc;

  axi_subsys_top dut (
    .i_aclk        (i_aclk),
    .i_rst         (i_rst),
    .i_if_req      (i_if_req),
    .i_if_addr     (i_if_addr),
    .i_if_size     (i_if_size),
    .o_if_addr_ok  (o_if_addr_ok),
    .o_if_data_ok  (o_if_data_ok),
    .i_mem_req     (i_mem_req),
    .i_mem_rw      (i_mem_rw),
    .o_mem_addr_ok (o_mem_addr_ok),
    .o_mem_data_ok (o_mem_data_ok),
    .o_rsp         (o_rsp)
  );

  always #4 i_aclk = ~i_aclk;  // 8 ns period

  always @(posedge i_aclk) cycle_cnt <= cycle_cnt + 1;

  // --------------------------------------------------
  // failure handling and compare tasks
  // --------------------------------------------------
  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_rsp(input string name, input rw_rsp_t got, input rw_rsp_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // --------------------------------------------------
  // case file loader
  // --------------------------------------------------
  task automatic load_cases();
    int    fd;
    int    n;
    int    port;
    int    wr;
    int    sz;
    int    err;
    addr_t addr;
    strb_t strb;
    data_t wdata;
    data_t rdata;
    string line;
    case_t c;
    fd = $fopen("rw_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file rw_cases.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#") begin  // skip blank and comment lines
        n = $sscanf(line, "%d %d %d %h %h %h %h %d",
                    port, wr, sz, addr, strb, wdata, rdata, err);
        if (n != 8) begin
          $display("malformed line in the case file: %s", line);
          abort_run();
        end
        c.port      = port;
        c.rw.wr     = wr[0];
        c.rw.size   = sz[1:0];
        c.rw.addr   = addr;
        c.rw.strb   = strb;
        c.rw.data   = wdata;
        c.exp.rdata = rdata;
        c.exp.err   = err[0];
        cases.push_back(c);
      end
    end
    $fclose(fd);
  endtask

  // --------------------------------------------------
  // one request on one port, from req to data_ok
  // --------------------------------------------------
  task automatic run_case(input case_t c, input int idx, output int ok_cyc);
    int    waited;
    logic  is_mem;
    string other_ok;
    is_mem   = (c.port != 0);
    other_ok = is_mem ? "o_if_data_ok" : "o_mem_data_ok";
    @(posedge i_aclk);
    #1;
    if (is_mem) begin
      i_mem_req = 1'b1;
      i_mem_rw  = c.rw;
    end else begin
      i_if_req  = 1'b1;
      i_if_addr = c.rw.addr;
      i_if_size = c.rw.size;
    end
    waited = 0;
    @(negedge i_aclk);
    while (!(is_mem ? o_mem_addr_ok : o_if_addr_ok)) begin  // request held until addr_ok
      if (waited == WAIT_LIMIT) begin
        $display("timeout waiting for addr_ok in case %0d", idx);
        abort_run();
      end
      waited++;
      @(negedge i_aclk);
    end
    ok_cyc = cycle_cnt;
    @(posedge i_aclk);
    #1;
    if (is_mem) begin
      i_mem_req = 1'b0;
      i_mem_rw  = ~c.rw;  // scrambled, the bridge must use its latched copy
    end else begin
      i_if_req  = 1'b0;
      i_if_addr = ~c.rw.addr;
    end
    waited = 0;
    @(negedge i_aclk);
    while (!(is_mem ? o_mem_data_ok : o_if_data_ok)) begin
      if (waited == WAIT_LIMIT) begin
        $display("timeout waiting for data_ok in case %0d", idx);
        abort_run();
      end
      waited++;
      @(negedge i_aclk);
    end
    check_flag($sformatf("%s (case %0d)", other_ok, idx),
               is_mem ? o_if_data_ok : o_mem_data_ok, 1'b0);
    check_rsp($sformatf("o_rsp (case %0d)", idx), o_rsp, c.exp);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    int i;
    i_aclk    = 1'b0;
    i_rst     = 1'b1;
    i_if_req  = 1'b0;
    i_if_addr = '0;
    i_if_size = '0;
    i_mem_req = 1'b0;
    i_mem_rw  = '0;
    load_cases();
    repeat (2) @(posedge i_aclk);
    #1;
    i_rst = 1'b0;
    i = 0;
    while (i < cases.size()) begin
      if (cases[i].port == 2) begin
        if (i + 1 >= cases.size() || cases[i+1].port != 0) begin
          $display("case %0d is paired but no fetch case follows it", i);
          abort_run();
        end
        fork  // both ports request in the same cycle
          run_case(cases[i], i, mem_ok_cyc);
          run_case(cases[i+1], i + 1, if_ok_cyc);
        join
        check_flag($sformatf("o_mem_addr_ok before o_if_addr_ok (case %0d)", i),
                   mem_ok_cyc < if_ok_cyc, 1'b1);
        i += 2;
      end else begin
        run_case(cases[i], i, mem_ok_cyc);
        i++;
      end
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== rw_cases.txt ====
# port (0 fetch, 1 data, 2 data issued with the next fetch line), wr, size, addr, strb,
# wdata, expected rdata, expected err; addr, strb and data in hex
1 1 3 80000000 ff 0123456789abcdef 0000000000000000 0
1 0 3 80000000 00 0000000000000000 0123456789abcdef 0
1 1 3 80000008 ff 1111111122222222 0000000000000000 0
1 1 3 80000008 0f aaaaaaaabbbbbbbb 0000000000000000 0
1 0 3 80000008 00 0000000000000000 11111111bbbbbbbb 0
1 1 3 80000008 a5 ccddeeff00112233 0000000000000000 0
1 0 3 80000008 00 0000000000000000 cc11ee11bb11bb33 0
0 0 3 80000000 00 0000000000000000 0123456789abcdef 0
1 1 3 80000ff8 ff deadbeefcafef00d 0000000000000000 0
0 0 2 80000ff8 00 0000000000000000 deadbeefcafef00d 0
2 1 3 80000010 ff 5555aaaa5555aaaa 0000000000000000 0
0 0 3 80000010 00 0000000000000000 5555aaaa5555aaaa 0
2 0 3 80000000 00 0000000000000000 0123456789abcdef 0
0 0 3 80000008 00 0000000000000000 cc11ee11bb11bb33 0
1 1 3 80001000 ff ffffffffffffffff 0000000000000000 1
1 0 3 80001000 00 0000000000000000 0000000000000000 1
1 1 3 7ffffff8 ff 0badf00d0badf00d 0000000000000000 1
0 0 3 00000000 00 0000000000000000 0000000000000000 1
1 0 3 80000000 00 0000000000000000 0123456789abcdef 0
1 0 3 80000ff8 00 0000000000000000 deadbeefcafef00d 0
1 1 3 80000100 ff 0f0f0f0f0f0f0f0f 0000000000000000 0
1 1 3 80000108 ff f0f0f0f0f0f0f0f0 0000000000000000 0
1 1 3 80000100 c3 123456789abcdef0 0000000000000000 0
1 0 3 80000100 00 0000000000000000 12340f0f0f0fdef0 0
0 0 3 80000108 00 0000000000000000 f0f0f0f0f0f0f0f0 0
1 0 3 80000010 00 0000000000000000 5555aaaa5555aaaa 0

// ==== flist.f ====
axi_pkg.sv
rw_arbiter.sv
axi4_master_bridge.sv
axi4_sram_slave.sv
axi_subsys_top.sv
axi_subsys_properties.sv
tb_axi_subsys.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run the testbench, then look for the pass line in sim.log
cd "$(dirname "$0")" \
  && rm -rf obj_dir sim.log \
  && verilator --binary --assert --top-module tb_axi_subsys -f flist.f -o tb_axi_subsys \
  && (./obj_dir/tb_axi_subsys > sim.log 2>&1 || true) \
  && grep -qx "TESTS PASSED" sim.log \
  && echo "run passed" \
  || { echo "run failed, see sim.log"; exit 1; }
